// ==== design/rx_link_pkg.sv ====
package rx_link_pkg;

  typedef logic [7:0]  byte_t;       // one link byte
  typedef logic [10:0] buf_addr_t;   // sized for the largest buffer
  typedef logic [11:0] frame_len_t;  // holds 2048
  typedef logic [15:0] crc_t;
  typedef logic [15:0] frame_cnt_t;

  localparam crc_t CRC_POLY = 16'h1021;  // ccitt
  localparam crc_t CRC_INIT = 16'hffff;

  // frame sequencer in rx_link_control
  typedef enum logic [2:0] {
    idle,
    first_byte,
    settle,
    wait_byte,
    byte_gap
  } link_state_t;

endpackage

// ==== design/rx_bit_deserializer.sv ====
`timescale 1ns/1ps

module rx_bit_deserializer (
  input  logic               clk,
  input  logic               reset,
  input  logic               bit_in,
  input  logic               bit_valid,
  input  logic               frame_gate,
  input  logic               rx_en,
  input  logic               rx_start,
  output logic               fram,
  output logic               rdy,
  output rx_link_pkg::byte_t data,
  output logic               done
);
  import rx_link_pkg::*;

  logic [6:0] shift_q;
  logic [2:0] bit_cnt;
  logic [2:0] cnt_base;
  logic       active;
  logic       take_bit;
  logic       byte_end;
  logic       gate_fall;

  assign take_bit  = bit_valid && rx_en && frame_gate;
  assign gate_fall = fram && !frame_gate;
  assign cnt_base  = rx_start ? 3'd0 : bit_cnt;  // start wins over a stale count
  assign byte_end  = take_bit && (cnt_base == 3'd7);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fram    <= 1'b0;
      rdy     <= 1'b0;
      bit_cnt <= 3'd0;
      active  <= 1'b0;
      done    <= 1'b0;
    end
    else
    begin
      fram <= frame_gate;
      rdy  <= byte_end;  // one cycle after the eighth bit

      if (gate_fall)
        bit_cnt <= 3'd0;  // partial byte is dropped
      else if (take_bit)
        bit_cnt <= cnt_base + 3'd1;
      else if (rx_start)
        bit_cnt <= 3'd0;

      if (rx_start)
      begin
        active <= 1'b1;
        done   <= 1'b0;
      end
      else if (gate_fall && active)
      begin
        active <= 1'b0;
        done   <= 1'b1;  // held until the next start
      end
    end
  end

  // shift path, msb first
  always_ff @(posedge clk)
  begin
    if (take_bit)
      shift_q <= {shift_q[5:0], bit_in};
    if (byte_end)
      data <= {shift_q, bit_in};  // stable until next byte
  end

endmodule

// ==== design/crc16_ccitt.sv ====
`timescale 1ns/1ps

module crc16_ccitt (
  input  logic               clk,
  input  logic               reset,
  input  logic               crc_init,
  input  logic               crc_en,
  input  rx_link_pkg::byte_t data,
  output rx_link_pkg::crc_t  crc_value
);
  import rx_link_pkg::*;

  // one byte through the register, msb first
  function automatic crc_t crc_fold(crc_t crc_in, byte_t din);
    crc_t r;
    r = crc_in ^ {din, 8'h00};
    for (int i = 0; i < 8; i++)
    begin
      if (r[15])
        r = (r << 1) ^ CRC_POLY;
      else
        r = r << 1;
    end
    return r;
  endfunction

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      crc_value <= CRC_INIT;
    else if (crc_init)
      crc_value <= CRC_INIT;
    else if (crc_en)
      crc_value <= crc_fold(crc_value, data);  // no final xor
  end

endmodule

// ==== design/rx_frame_buffer.sv ====
`timescale 1ns/1ps

module rx_frame_buffer #(
  parameter int buf_depth_log2 = 11
) (
  input  logic                   clk,
  input  logic                   we,
  input  rx_link_pkg::buf_addr_t waddr,
  input  rx_link_pkg::byte_t     wd,
  input  rx_link_pkg::buf_addr_t rd_addr,
  output rx_link_pkg::byte_t     rd_data
);
  import rx_link_pkg::*;

  localparam int depth = 1 << buf_depth_log2;

  byte_t mem [0:depth-1];

  logic [buf_depth_log2-1:0] wa;
  logic [buf_depth_log2-1:0] ra;

  assign wa = waddr[buf_depth_log2-1:0];
  assign ra = rd_addr[buf_depth_log2-1:0];  // upper bits ignored on small buffers

  always_ff @(posedge clk)
  begin
    if (we)
      mem[wa] <= wd;
  end

  // registered read, one cycle latency
  always_ff @(posedge clk)
  begin
    rd_data <= mem[ra];
  end

endmodule

// ==== design/rx_frame_status.sv ====
`timescale 1ns/1ps

module rx_frame_status (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    crc_init,
  input  logic                    crc_en,
  input  logic                    crc_end,
  input  rx_link_pkg::crc_t       crc_value,
  output logic                    frame_valid,
  output rx_link_pkg::frame_len_t frame_len,
  output logic                    crc_ok,
  output rx_link_pkg::frame_cnt_t frame_count
);
  import rx_link_pkg::*;

  frame_len_t byte_cnt;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      byte_cnt    <= '0;
      frame_valid <= 1'b0;
      frame_count <= '0;
    end
    else
    begin
      frame_valid <= crc_end;  // one cycle after crc_end
      if (crc_init)
        byte_cnt <= '0;
      else if (crc_en)
        byte_cnt <= byte_cnt + 1'b1;
      if (crc_end)
        frame_count <= frame_count + 1'b1;
    end
  end

  // results held until the next frame ends
  always_ff @(posedge clk)
  begin
    if (crc_end)
    begin
      frame_len <= byte_cnt;
      crc_ok    <= (crc_value == '0);  // residue over data and crc bytes
    end
  end

endmodule

// ==== design/rx_link_control.sv ====
`timescale 1ns/1ps

module rx_link_control #(
  parameter int buf_depth_log2 = 11
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rdy,
  input  rx_link_pkg::byte_t     data,
  input  logic                   done,
  input  logic                   fram,
  input  logic                   phaselock,
  output logic                   rx_en,
  output logic                   rx_start,
  output rx_link_pkg::buf_addr_t waddr,
  output rx_link_pkg::byte_t     wd,
  output logic                   wen,
  output logic                   crc_en,
  output logic                   crc_init,
  output logic                   crc_end
);
  import rx_link_pkg::*;

  localparam buf_addr_t addr_mask = buf_addr_t'((1 << buf_depth_log2) - 1);

  link_state_t state;
  logic [1:0]  fram_edge;
  logic [1:0]  done_edge;
  logic        rdy_q;
  byte_t       data0;
  logic        fram_rise;
  logic        done_rise;
  logic        byte_take;

  assign fram_rise = (fram_edge == 2'b01);
  assign done_rise = (done_edge == 2'b01);
  assign byte_take = rdy_q && (done_edge == 2'b00);  // no bytes once done is seen
  assign wd        = data0;

  // edge detectors
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fram_edge <= 2'b00;
      done_edge <= 2'b00;
      rdy_q     <= 1'b0;
    end
    else
    begin
      fram_edge <= {fram_edge[0], fram};
      done_edge <= {done_edge[0], done};
      rdy_q     <= rdy;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state    <= idle;
      waddr    <= '0;
      wen      <= 1'b0;
      rx_en    <= 1'b0;
      rx_start <= 1'b0;
      crc_en   <= 1'b0;
      crc_init <= 1'b0;
      crc_end  <= 1'b0;
    end
    else
    begin
      rx_start <= 1'b0;
      crc_init <= 1'b0;
      crc_en   <= 1'b0;
      crc_end  <= 1'b0;

      if (state != idle && done_rise)
      begin
        // frame closes from any active state
        waddr   <= '0;
        crc_end <= 1'b1;
        wen     <= 1'b0;
        rx_en   <= 1'b0;  // low for one cycle
        state   <= idle;
      end
      else
      begin
        case (state)
          idle:
          begin
            rx_en <= 1'b1;
            if (fram_rise && phaselock)
            begin
              wen      <= 1'b1;
              crc_init <= 1'b1;
              rx_start <= 1'b1;
              state    <= first_byte;
            end
          end

          first_byte:
            if (byte_take)
            begin
              data0  <= data;
              waddr  <= '0;  // first byte at address 0
              crc_en <= 1'b1;
              state  <= settle;
            end

          settle:
            state <= wait_byte;

          wait_byte:
            if (byte_take)
            begin
              data0  <= data;
              waddr  <= (waddr + 1'b1) & addr_mask;  // wraps at buffer size
              crc_en <= 1'b1;
              state  <= byte_gap;
            end

          byte_gap:
            state <= settle;

          default:
            state <= idle;
        endcase
      end
    end
  end

endmodule

// ==== design/rx_link_top.sv ====
`timescale 1ns/1ps

module rx_link_top #(
  parameter int buf_depth_log2 = 11
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    bit_in,
  input  logic                    bit_valid,
  input  logic                    frame_gate,
  input  logic                    phaselock,
  input  rx_link_pkg::buf_addr_t  rd_addr,
  output rx_link_pkg::byte_t      rd_data,
  output logic                    frame_valid,
  output rx_link_pkg::frame_len_t frame_len,
  output logic                    crc_ok,
  output rx_link_pkg::frame_cnt_t frame_count,
  output logic                    rx_busy
);
  import rx_link_pkg::*;

  logic      fram;
  logic      rdy;
  logic      done;
  logic      rx_en;
  logic      rx_start;
  logic      crc_en;
  logic      crc_init;
  logic      crc_end;
  byte_t     rx_data;
  byte_t     wd;
  buf_addr_t waddr;
  crc_t      crc_value;

  rx_bit_deserializer u_rx_bit_deserializer (
    .clk        (clk),
    .reset      (reset),
    .bit_in     (bit_in),
    .bit_valid  (bit_valid),
    .frame_gate (frame_gate),
    .rx_en      (rx_en),
    .rx_start   (rx_start),
    .fram       (fram),
    .rdy        (rdy),
    .data       (rx_data),
    .done       (done)
  );

  rx_link_control #(
    .buf_depth_log2 (buf_depth_log2)
  ) u_rx_link_control (
    .clk       (clk),
    .reset     (reset),
    .rdy       (rdy),
    .data      (rx_data),
    .done      (done),
    .fram      (fram),
    .phaselock (phaselock),
    .rx_en     (rx_en),
    .rx_start  (rx_start),
    .waddr     (waddr),
    .wd        (wd),
    .wen       (rx_busy),  // frame-active level
    .crc_en    (crc_en),
    .crc_init  (crc_init),
    .crc_end   (crc_end)
  );

  crc16_ccitt u_crc16_ccitt (
    .clk       (clk),
    .reset     (reset),
    .crc_init  (crc_init),
    .crc_en    (crc_en),
    .data      (wd),
    .crc_value (crc_value)
  );

  rx_frame_buffer #(
    .buf_depth_log2 (buf_depth_log2)
  ) u_rx_frame_buffer (
    .clk     (clk),
    .we      (crc_en),  // byte strobe doubles as write
    .waddr   (waddr),
    .wd      (wd),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  rx_frame_status u_rx_frame_status (
    .clk         (clk),
    .reset       (reset),
    .crc_init    (crc_init),
    .crc_en      (crc_en),
    .crc_end     (crc_end),
    .crc_value   (crc_value),
    .frame_valid (frame_valid),
    .frame_len   (frame_len),
    .crc_ok      (crc_ok),
    .frame_count (frame_count)
  );

endmodule

// ==== testbench/rx_link_properties.sv ====
`timescale 1ns/1ps

module rx_link_properties (
  input logic clk,
  input logic reset,
  input logic crc_en,
  input logic crc_init,
  input logic crc_end,
  input logic wen
);

  // one write strobe per byte
  crc_en_single: assert property (@(posedge clk) disable iff (reset) crc_en |=> !crc_en)
    else $error("crc_en high on two consecutive cycles");

  init_end_apart: assert property (@(posedge clk) disable iff (reset) !(crc_init && crc_end))
    else $error("crc_init and crc_end in the same cycle");

  // frame-active level drops only when the frame closes
  wen_fall_at_end: assert property (@(posedge clk) disable iff (reset) $fell(wen) |-> crc_end)
    else $error("wen fell without crc_end");

endmodule

// ==== testbench/rx_link_tb.sv ====
`timescale 1ns/1ps

module rx_link_tb;
  import rx_link_pkg::*;

  logic       clk;
  logic       reset;
  logic       bit_in;
  logic       bit_valid;
  logic       frame_gate;
  logic       phaselock;
  buf_addr_t  rd_addr;
  byte_t      rd_data;
  logic       frame_valid;
  frame_len_t frame_len;
  logic       crc_ok;
  frame_cnt_t frame_count;
  logic       rx_busy;
  byte_t      frame_q[$];  // payload plus crc, as sent
  int         errors;
  int         timeouts;

  rx_link_top #(.buf_depth_log2(11)) u_rx_link_top (.*);

  bind rx_link_control rx_link_properties u_rx_link_properties (
    .clk(clk), .reset(reset), .crc_en(crc_en),
    .crc_init(crc_init), .crc_end(crc_end), .wen(wen)
  );

  always #50 clk = ~clk;

  task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("FAILED %0t: %s got %0h expected %0h", $time, what, got, exp);
  endtask

  task automatic check_byte(byte_t got, byte_t exp, string what);
    if (got !== exp)
      report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_len(frame_len_t got, frame_len_t exp, string what);
    if (got !== exp)
      report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_count(frame_cnt_t got, frame_cnt_t exp, string what);
    if (got !== exp)
      report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_crc_ok(logic got, logic exp, string what);
    if (got !== exp)
      report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic check_busy(logic got, logic exp, string what);
    if (got !== exp)
      report_mismatch(what, 32'(got), 32'(exp));
  endtask

  // bit-serial reference crc over the first n bytes
  function automatic crc_t ref_crc(int n);
    crc_t c;
    c = 16'hffff;
    for (int i = 0; i < n; i++)
      for (int b = 7; b >= 0; b--)
        c = {c[14:0], 1'b0} ^ ((c[15] ^ frame_q[i][b]) ? 16'h1021 : 16'h0000);
    return c;
  endfunction

  task automatic build_frame(int n, bit corrupt);
    crc_t c;
    frame_q.delete();
    for (int i = 0; i < n; i++)
      frame_q.push_back(byte_t'($urandom));
    c = ref_crc(n);
    frame_q.push_back(c[15:8]);  // big-endian
    frame_q.push_back(c[7:0]);
    if (corrupt)
      frame_q[n / 2] = frame_q[n / 2] ^ 8'h10;  // one payload bit
  endtask

  task automatic send_byte(byte_t b);
    for (int i = 7; i >= 0; i--)
    begin
      bit_in    = b[i];
      bit_valid = 1'b1;
      @(negedge clk);
      bit_valid = 1'b0;
      repeat (7) @(negedge clk);  // 8 cycles per bit
    end
  endtask

  task automatic send_frame(int n);
    frame_gate = 1'b1;
    repeat (8) @(negedge clk);  // controller start-up
    check_busy(rx_busy, phaselock, "rx_busy at frame start");  // only locked frames start
    for (int i = 0; i < n; i++)
      send_byte(frame_q[i]);
  endtask

  task automatic end_frame(int max_cycles, output bit seen);
    int n;
    frame_gate = 1'b0;
    seen = 1'b0;
    for (n = 0; n < max_cycles && !seen; n++)
    begin
      @(negedge clk);
      seen = frame_valid;
    end
  endtask

  task automatic receive_frame(int n, bit corrupt, frame_cnt_t exp_count);
    bit seen;
    build_frame(n, corrupt);
    send_frame(n + 2);
    end_frame(64, seen);
    if (!seen)
    begin
      timeouts++;
      $display("timeout: no frame_valid within 64 cycles after the gate fell");
    end
    check_len(frame_len, frame_len_t'(n + 2), "frame_len");
    check_crc_ok(crc_ok, !corrupt, "crc_ok");
    check_count(frame_count, exp_count, "frame_count");
    check_busy(rx_busy, 1'b0, "rx_busy after frame end");
    repeat (8) @(negedge clk);  // gap before next frame
  endtask

  task automatic check_buffer();
    for (int i = 0; i < frame_q.size(); i++)
    begin
      rd_addr = buf_addr_t'(i);
      @(negedge clk);
      check_byte(rd_data, frame_q[i], $sformatf("buffer[%0d]", i));
    end
  endtask

  task automatic apply_reset();
    reset      = 1'b1;
    frame_gate = 1'b0;
    bit_valid  = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic test_good_frame();
    receive_frame(16, 1'b0, 16'd1);
    check_buffer();
  endtask

  task automatic test_corrupt_frame();
    receive_frame(16, 1'b1, 16'd2);
    check_buffer();  // received bytes kept
  endtask

  task automatic test_no_phaselock();
    bit seen;
    phaselock = 1'b0;
    build_frame(8, 1'b0);
    send_frame(10);
    end_frame(2400, seen);  // 300 bit times
    if (seen)
      report_mismatch("frame_valid with phaselock low", 32'd1, 32'd0);
    check_count(frame_count, 16'd2, "frame_count");
    phaselock = 1'b1;
    repeat (8) @(negedge clk);
  endtask

  task automatic test_back_to_back();
    receive_frame(24, 1'b0, 16'd3);
    receive_frame(10, 1'b1, 16'd4);
    check_buffer();  // shorter frame over the longer one
  endtask

  task automatic test_reset_mid_frame();
    build_frame(16, 1'b0);
    send_frame(5);
    apply_reset();
    check_count(frame_count, 16'd0, "frame_count after reset");
    check_busy(rx_busy, 1'b0, "rx_busy after reset");
    receive_frame(16, 1'b0, 16'd1);
    check_buffer();
  endtask

  initial
  begin
    void'($urandom(18643));
    errors     = 0;
    timeouts   = 0;
    clk        = 1'b0;
    bit_in     = 1'b0;
    bit_valid  = 1'b0;
    frame_gate = 1'b0;
    phaselock  = 1'b1;
    rd_addr    = '0;
    apply_reset();
    test_good_frame();
    test_corrupt_frame();
    test_no_phaselock();
    test_back_to_back();
    test_reset_mid_frame();
    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== list.f ====
design/rx_link_pkg.sv
design/rx_bit_deserializer.sv
design/crc16_ccitt.sv
design/rx_frame_buffer.sv
design/rx_frame_status.sv
design/rx_link_control.sv
design/rx_link_top.sv
testbench/rx_link_properties.sv
testbench/rx_link_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= rx_link_tb
DUT_TOP    ?= rx_link_top
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
